/* Bender.yml */
package:
  name: branch_unit

sources:
  - src/branch_pkg.sv
  - src/br_req_if.sv
  - src/branch_cond.sv
  - src/branch_resolve.sv
  - src/branch_cu.sv
  - src/branch_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_branch_unit.sv

/* src.f */
+incdir+include
src/branch_pkg.sv
src/br_req_if.sv
src/branch_cond.sv
src/branch_resolve.sv
src/branch_cu.sv
src/branch_unit.sv
test/tb_branch_unit.sv

/* src/br_req_if.sv */
// One branch request per valid cycle with no acceptance signal; issue must hold off while stalled
`default_nettype none

interface br_req_if;

    // Request strobe, one cycle per branch
    logic                 valid;
    // Operation and operands
    branch_pkg::br_op_t   op;
    branch_pkg::data_t    rs1;
    branch_pkg::data_t    rs2;
    branch_pkg::addr_t    pc;
    branch_pkg::data_t    imm;
    // Frontend prediction for this branch
    logic                 pred_taken;
    branch_pkg::addr_t    pred_target;

    // Issue side drives the request
    modport issue (
        output valid, op, rs1, rs2, pc, imm, pred_taken, pred_target
    );

    // Branch unit side only samples it
    modport bu (
        input valid, op, rs1, rs2, pc, imm, pred_taken, pred_target
    );

endinterface

`default_nettype wire

/* src/branch_cond.sv */
// Pure combinational compare; JAL and JALR report taken regardless of operands
`default_nettype none

module branch_cond (
    input  branch_pkg::br_op_t op_i,
    input  branch_pkg::data_t  rs1_i,
    input  branch_pkg::data_t  rs2_i,
    output logic               taken_o
);

    // ----------------------------------------------------------------------
    // Comparisons
    // ----------------------------------------------------------------------

    logic is_eq;
    logic is_lt_s;
    logic is_lt_u;

    // Equality shared by BEQ and BNE
    assign is_eq   = (rs1_i == rs2_i);
    // Two's complement less than
    assign is_lt_s = ($signed(rs1_i) < $signed(rs2_i));
    // Magnitude less than
    assign is_lt_u = (rs1_i < rs2_i);

    // ----------------------------------------------------------------------
    // Decode
    // ----------------------------------------------------------------------

    // All eight codes are used so no default arm is needed
    always_comb begin : cond_decode
        taken_o = 1'b0;
        case (op_i)
            branch_pkg::BR_BEQ:  taken_o = is_eq;
            branch_pkg::BR_BNE:  taken_o = !is_eq;
            branch_pkg::BR_BLT:  taken_o = is_lt_s;
            branch_pkg::BR_BGE:  taken_o = !is_lt_s;
            branch_pkg::BR_BLTU: taken_o = is_lt_u;
            branch_pkg::BR_BGEU: taken_o = !is_lt_u;
            // Jumps always redirect
            branch_pkg::BR_JAL:  taken_o = 1'b1;
            branch_pkg::BR_JALR: taken_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* src/branch_cu.sv */
// Stalls after every misprediction until flush_i; flush_i does not clear the result register
`default_nettype none

module branch_cu (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,
    br_req_if.bu req,
    input  logic mispredict_i,
    input  logic fe_ready_i,
    output logic issue_mis_o,
    output logic fe_res_valid_o,
    output logic res_reg_en_o
);

    // ----------------------------------------------------------------------
    // State
    // ----------------------------------------------------------------------

    typedef enum logic [1:0] {
        IDLE,
        UPD_FE,
        MIS,
        STALL
    } cu_state_t;

    cu_state_t curr_state;
    cu_state_t next_state;

    // ----------------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------------

    always_comb begin : cu_next
        next_state = curr_state;
        case (curr_state)
            // Accept a request in either of these
            IDLE, UPD_FE: begin
                if (req.valid && mispredict_i) begin
                    next_state = MIS;
                end else if (req.valid) begin
                    next_state = UPD_FE;
                end else begin
                    next_state = IDLE;
                end
            end
            // Hold until the frontend takes the redirect
            MIS: begin
                if (fe_ready_i) begin
                    next_state = STALL;
                end
            end
            // Only a flush leaves this state
            STALL:   next_state = STALL;
            default: next_state = IDLE;
        endcase
    end

    // ----------------------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------------------

    // Moore outputs
    always_comb begin : cu_out
        issue_mis_o    = 1'b0;
        fe_res_valid_o = 1'b0;
        res_reg_en_o   = 1'b0;
        case (curr_state)
            IDLE: res_reg_en_o = 1'b1;
            // Pulse the correct result and keep loading
            UPD_FE: begin
                fe_res_valid_o = 1'b1;
                res_reg_en_o   = 1'b1;
            end
            MIS: begin
                fe_res_valid_o = 1'b1;
                issue_mis_o    = 1'b1;
            end
            default: ;
        endcase
    end

    // Flush wins over normal progression
    always_ff @(posedge clk_i or negedge rst_n_i) begin : cu_state_reg
        if (!rst_n_i) begin
            curr_state <= IDLE;
        end else if (flush_i) begin
            curr_state <= IDLE;
        end else begin
            curr_state <= next_state;
        end
    end

endmodule

`default_nettype wire

/* src/branch_pkg.sv */
// Shared widths and branch codes for RV32 only; op codes are internal and not the funct3 field
`default_nettype none

package branch_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------

    // Data and address width
    localparam int unsigned XLEN = 32;
    // No compressed instructions
    localparam int unsigned INSTR_BYTES = 4;
    // Branch operation code width
    localparam int unsigned BR_OP_W = 3;

    // ----------------------------------------------------------------------
    // Types
    // ----------------------------------------------------------------------

    // Register operands and immediates
    typedef logic [XLEN-1:0] data_t;
    // Program counters and targets
    typedef logic [XLEN-1:0] addr_t;
    // Branch operation
    typedef logic [BR_OP_W-1:0] br_op_t;

    // ----------------------------------------------------------------------
    // Branch operation codes
    // ----------------------------------------------------------------------

    // Conditional branches
    localparam br_op_t BR_BEQ  = 3'd0;
    localparam br_op_t BR_BNE  = 3'd1;
    localparam br_op_t BR_BLT  = 3'd2;
    localparam br_op_t BR_BGE  = 3'd3;
    localparam br_op_t BR_BLTU = 3'd4;
    localparam br_op_t BR_BGEU = 3'd5;
    // Unconditional jumps
    localparam br_op_t BR_JAL  = 3'd6;
    localparam br_op_t BR_JALR = 3'd7;

endpackage

`default_nettype wire

/* src/branch_resolve.sv */
// No alignment check on targets; the result register loads only on valid with enable set
`default_nettype none

module branch_resolve (
    input  logic              clk_i,
    input  logic              rst_n_i,
    br_req_if.bu              req,
    input  logic              res_reg_en_i,
    output logic              mispredict_o,
    output branch_pkg::addr_t res_pc_o,
    output branch_pkg::addr_t res_target_o,
    output logic              res_taken_o,
    output logic              res_mispredict_o
);

    // ----------------------------------------------------------------------
    // Internal signals
    // ----------------------------------------------------------------------

    logic              taken;
    branch_pkg::addr_t jalr_sum;
    branch_pkg::addr_t target;
    branch_pkg::addr_t seq_pc;
    branch_pkg::addr_t next_pc;
    logic              res_load;

    // Taken or not taken from the comparator
    branch_cond u_cond (
        .op_i    (req.op),
        .rs1_i   (req.rs1),
        .rs2_i   (req.rs2),
        .taken_o (taken)
    );

    // ----------------------------------------------------------------------
    // Target and next address
    // ----------------------------------------------------------------------

    // Register relative jump base
    assign jalr_sum = req.rs1 + req.imm;

    // JALR clears bit 0, everything else is pc relative
    assign target = (req.op == branch_pkg::BR_JALR) ?
                    {jalr_sum[branch_pkg::XLEN-1:1], 1'b0} :
                    req.pc + req.imm;

    // Fall through address
    assign seq_pc  = req.pc + branch_pkg::addr_t'(branch_pkg::INSTR_BYTES);
    assign next_pc = taken ? target : seq_pc;

    // Wrong direction, or right direction with the wrong target
    assign mispredict_o = (req.pred_taken != taken) ||
                          (taken && (req.pred_target != target));

    // ----------------------------------------------------------------------
    // Result register
    // ----------------------------------------------------------------------

    // Frozen while the control unit holds a misprediction
    assign res_load = req.valid && res_reg_en_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin : res_reg
        if (!rst_n_i) begin
            res_pc_o         <= '0;
            res_target_o     <= '0;
            res_taken_o      <= 1'b0;
            res_mispredict_o <= 1'b0;
        end else if (res_load) begin
            res_pc_o         <= req.pc;
            // Frontend wants the resolved next fetch address
            res_target_o     <= next_pc;
            res_taken_o      <= taken;
            res_mispredict_o <= mispredict_o;
        end
    end

endmodule

`default_nettype wire

/* src/branch_unit.sv */
// Issue must not send while issue_mis_o is high or the unit is stalled; link writeback is external
`default_nettype none

module branch_unit (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               flush_i,
    // Request from issue
    input  logic               valid_i,
    input  branch_pkg::br_op_t op_i,
    input  branch_pkg::data_t  rs1_i,
    input  branch_pkg::data_t  rs2_i,
    input  branch_pkg::data_t  imm_i,
    input  branch_pkg::addr_t  pc_i,
    input  branch_pkg::addr_t  pred_target_i,
    input  logic               pred_taken_i,
    // Frontend back-pressure on mispredictions
    input  logic               fe_ready_i,
    output logic               issue_mis_o,
    // Resolution to the frontend
    output logic               fe_res_valid_o,
    output branch_pkg::addr_t  fe_res_pc_o,
    output branch_pkg::addr_t  fe_res_target_o,
    output logic               fe_res_taken_o,
    output logic               fe_res_mispredict_o
);

    // ----------------------------------------------------------------------
    // Request bundle
    // ----------------------------------------------------------------------

    br_req_if u_req ();

    assign u_req.valid       = valid_i;
    assign u_req.op          = op_i;
    assign u_req.rs1         = rs1_i;
    assign u_req.rs2         = rs2_i;
    assign u_req.pc          = pc_i;
    assign u_req.imm         = imm_i;
    assign u_req.pred_taken  = pred_taken_i;
    assign u_req.pred_target = pred_target_i;

    // ----------------------------------------------------------------------
    // Datapath and control
    // ----------------------------------------------------------------------

    logic mispredict;
    logic res_reg_en;

    branch_resolve u_resolve (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .req              (u_req.bu),
        .res_reg_en_i     (res_reg_en),
        .mispredict_o     (mispredict),
        .res_pc_o         (fe_res_pc_o),
        .res_target_o     (fe_res_target_o),
        .res_taken_o      (fe_res_taken_o),
        .res_mispredict_o (fe_res_mispredict_o)
    );

    // Sequences notification, stall and flush
    branch_cu u_cu (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .req            (u_req.bu),
        .mispredict_i   (mispredict),
        .fe_ready_i     (fe_ready_i),
        .issue_mis_o    (issue_mis_o),
        .fe_res_valid_o (fe_res_valid_o),
        .res_reg_en_o   (res_reg_en)
    );

endmodule

`default_nettype wire

/* include/tb_branch_checks.svh */
// Included inside tb_branch_unit only; relies on its abort_run task and stops at the first mismatch
`ifndef TB_BRANCH_CHECKS_SVH
`define TB_BRANCH_CHECKS_SVH

// ----------------------------------------------------------------------
// Typed compare tasks
// ----------------------------------------------------------------------

// Address or data field compare
task automatic check_addr(input string name, input branch_pkg::addr_t exp,
                          input branch_pkg::addr_t act);
    if (act !== exp) begin
        $display("FAILED t=%0t %s: expected %h, actual %h", $time, name, exp, act);
        abort_run("Value mismatch on a DUT output");
    end
endtask

// Single bit compare, X counts as a mismatch
task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("FAILED t=%0t %s: expected %b, actual %b", $time, name, exp, act);
        abort_run("Value mismatch on a DUT output");
    end
endtask

// ----------------------------------------------------------------------
// Reference model of one branch resolution
// ----------------------------------------------------------------------

task automatic resolve_model(input branch_pkg::br_op_t op, input branch_pkg::data_t rs1,
                             input branch_pkg::data_t rs2, input branch_pkg::data_t imm,
                             input branch_pkg::addr_t pc, input logic pred_taken,
                             input branch_pkg::addr_t pred_target, output logic taken,
                             output branch_pkg::addr_t target,
                             output branch_pkg::addr_t next_pc, output logic mis);
    logic lt_u;
    logic lt_s;
    lt_u = (rs1 < rs2);
    // Signed order by flipping the sign bits, then unsigned compare
    lt_s = ((rs1 ^ 32'h8000_0000) < (rs2 ^ 32'h8000_0000));
    case (op)
        branch_pkg::BR_BEQ:  taken = (rs1 == rs2);
        branch_pkg::BR_BNE:  taken = (rs1 != rs2);
        branch_pkg::BR_BLT:  taken = lt_s;
        branch_pkg::BR_BGE:  taken = ~lt_s;
        branch_pkg::BR_BLTU: taken = lt_u;
        branch_pkg::BR_BGEU: taken = ~lt_u;
        default:             taken = 1'b1;
    endcase
    // JALR is register based with bit 0 forced low
    if (op == branch_pkg::BR_JALR) begin
        target = (rs1 + imm) & ~32'd1;
    end else begin
        target = pc + imm;
    end
    next_pc = taken ? target : pc + branch_pkg::INSTR_BYTES;
    mis     = (pred_taken != taken) || (taken && pred_taken && (pred_target != target));
endtask

`endif

/* test/tb_branch_unit.sv */
// Directed tests only; relies on the one cycle result latency and on flush_i to leave STALL
`default_nettype none

module tb_branch_unit;

    timeunit 1ns;
    timeprecision 100ps;

    // ----------------------------------------------------------------------
    // Clock, DUT signals and expected values
    // ----------------------------------------------------------------------

    localparam int CLK_HALF = 2;
    // Roughly 110 cycles of tests plus margin
    localparam int WATCHDOG_CYCLES = 160;

    logic clk_i;
    logic rst_n_i;
    logic flush_i;
    logic valid_i;
    branch_pkg::br_op_t op_i;
    branch_pkg::data_t rs1_i;
    branch_pkg::data_t rs2_i;
    branch_pkg::data_t imm_i;
    branch_pkg::addr_t pc_i;
    branch_pkg::addr_t pred_target_i;
    logic pred_taken_i;
    logic fe_ready_i;
    logic issue_mis_o;
    logic fe_res_valid_o;
    branch_pkg::addr_t fe_res_pc_o;
    branch_pkg::addr_t fe_res_target_o;
    logic fe_res_taken_o;
    logic fe_res_mispredict_o;

    // Model result of the last accepted request
    branch_pkg::addr_t exp_pc;
    branch_pkg::addr_t exp_next;
    logic exp_taken;
    logic exp_mis;
    integer seed = 23;

    branch_unit u_dut (.*);

    always #(CLK_HALF) clk_i = ~clk_i;

    // Fail path shared by checks and watchdog
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    `include "tb_branch_checks.svh"

    // ----------------------------------------------------------------------
    // Drive helpers, all inputs change 1 ns after the rising edge
    // ----------------------------------------------------------------------

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    function automatic branch_pkg::data_t rand_data();
        rand_data = $random(seed);
    endfunction

    // Word aligned program counter
    function automatic branch_pkg::addr_t rand_pc();
        rand_pc = branch_pkg::addr_t'($random(seed)) & ~32'd3;
    endfunction

    task automatic drive_idle();
        valid_i = 1'b0;
        op_i = branch_pkg::BR_BEQ;
        rs1_i = '0;
        rs2_i = '0;
        imm_i = '0;
        pc_i = '0;
        pred_taken_i = 1'b0;
        pred_target_i = '0;
    endtask

    // Request that the DUT must ignore, expectations untouched
    task automatic drive_stray();
        valid_i = 1'b1;
        op_i = branch_pkg::BR_BNE;
        rs1_i = rand_data();
        rs2_i = rand_data();
        imm_i = rand_data() & ~32'd1;
        pc_i = rand_pc();
        pred_taken_i = 1'b0;
        pred_target_i = rand_pc();
    endtask

    task automatic apply_req(input branch_pkg::br_op_t op, input branch_pkg::data_t rs1,
                             input branch_pkg::data_t rs2, input branch_pkg::data_t imm,
                             input branch_pkg::addr_t pc, input logic pred_taken,
                             input branch_pkg::addr_t pred_target);
        branch_pkg::addr_t target;
        valid_i = 1'b1;
        op_i = op;
        rs1_i = rs1;
        rs2_i = rs2;
        imm_i = imm;
        pc_i = pc;
        pred_taken_i = pred_taken;
        pred_target_i = pred_target;
        exp_pc = pc;
        resolve_model(op, rs1, rs2, imm, pc, pred_taken, pred_target,
                      exp_taken, target, exp_next, exp_mis);
    endtask

    // Prediction taken from the model, so no misprediction
    task automatic apply_correct(input branch_pkg::br_op_t op, input branch_pkg::data_t rs1,
                                 input branch_pkg::data_t rs2, input branch_pkg::data_t imm,
                                 input branch_pkg::addr_t pc);
        logic taken;
        logic mis;
        branch_pkg::addr_t target;
        branch_pkg::addr_t next_pc;
        resolve_model(op, rs1, rs2, imm, pc, 1'b0, '0, taken, target, next_pc, mis);
        apply_req(op, rs1, rs2, imm, pc, taken, target);
    endtask

    // ----------------------------------------------------------------------
    // Output checks
    // ----------------------------------------------------------------------

    task automatic check_fields();
        check_addr("fe_res_pc_o", exp_pc, fe_res_pc_o);
        check_addr("fe_res_target_o", exp_next, fe_res_target_o);
        check_bit("fe_res_taken_o", exp_taken, fe_res_taken_o);
        check_bit("fe_res_mispredict_o", exp_mis, fe_res_mispredict_o);
    endtask

    task automatic check_result();
        check_bit("fe_res_valid_o", 1'b1, fe_res_valid_o);
        check_bit("issue_mis_o", exp_mis, issue_mis_o);
        check_fields();
    endtask

    task automatic check_quiet();
        check_bit("fe_res_valid_o", 1'b0, fe_res_valid_o);
        check_bit("issue_mis_o", 1'b0, issue_mis_o);
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------

    task automatic test_reset();
        check_quiet();
        check_bit("fe_res_mispredict_o", 1'b0, fe_res_mispredict_o);
        check_bit("fe_res_taken_o", 1'b0, fe_res_taken_o);
        check_addr("fe_res_pc_o", '0, fe_res_pc_o);
        check_addr("fe_res_target_o", '0, fe_res_target_o);
    endtask

    // Equal values, sign bit differences and random pairs per condition
    task automatic test_conditions();
        branch_pkg::br_op_t ops[6];
        branch_pkg::data_t a[5];
        branch_pkg::data_t b[5];
        branch_pkg::data_t r;
        ops = '{branch_pkg::BR_BEQ, branch_pkg::BR_BNE, branch_pkg::BR_BLT,
                branch_pkg::BR_BGE, branch_pkg::BR_BLTU, branch_pkg::BR_BGEU};
        for (int k = 0; k < 6; k++) begin
            r = rand_data();
            a = '{r, 32'h8000_0000, 32'h0000_0001, 32'hffff_ffff, rand_data()};
            b = '{r, 32'h0000_0001, 32'h8000_0000, 32'h0000_0000, rand_data()};
            for (int i = 0; i < 5; i++) begin
                apply_correct(ops[k], a[i], b[i], rand_data() & ~32'd1, rand_pc());
                next_cycle();
                check_result();
                drive_idle();
                next_cycle();
                check_quiet();
            end
        end
    endtask

    // Back to back jumps, JALR sums are odd
    task automatic test_jumps();
        branch_pkg::br_op_t op;
        for (int i = 0; i < 8; i++) begin
            op = (i % 2) ? branch_pkg::BR_JALR : branch_pkg::BR_JAL;
            apply_correct(op, rand_data() | 32'd1, rand_data(), rand_data() & ~32'd1, rand_pc());
            next_cycle();
            check_result();
            if (op == branch_pkg::BR_JALR) begin
                check_bit("fe_res_target_o[0]", 1'b0, fe_res_target_o[0]);
            end
        end
        drive_idle();
        next_cycle();
        check_quiet();
    endtask

    // Hold under back-pressure, stall, then flush out of STALL
    task automatic test_mispredict(input bit wrong_target);
        branch_pkg::addr_t pc;
        branch_pkg::data_t r;
        pc = rand_pc();
        r = rand_data();
        fe_ready_i = 1'b0;
        if (wrong_target) begin
            apply_req(branch_pkg::BR_JAL, r, r, 32'h40, pc, 1'b1, pc + 32'h48);
        end else begin
            apply_req(branch_pkg::BR_BEQ, r, r, 32'h100, pc, 1'b0, '0);
        end
        next_cycle();
        check_result();
        repeat (4) begin
            drive_stray();
            next_cycle();
            check_result();
        end
        drive_idle();
        fe_ready_i = 1'b1;
        next_cycle();
        fe_ready_i = 1'b0;
        check_quiet();
        // STALL ignores requests and keeps the register
        repeat (3) begin
            drive_stray();
            next_cycle();
            check_quiet();
            check_fields();
        end
        drive_idle();
        flush_i = 1'b1;
        next_cycle();
        flush_i = 1'b0;
        check_quiet();
        check_fields();
        apply_correct(branch_pkg::BR_BNE, 32'd1, 32'd2, 32'h20, rand_pc());
        next_cycle();
        check_result();
        drive_idle();
        next_cycle();
        check_quiet();
    endtask

    task automatic test_flush_in_mis();
        apply_req(branch_pkg::BR_BLTU, 32'd1, 32'd2, 32'h80, rand_pc(), 1'b0, '0);
        next_cycle();
        check_result();
        drive_idle();
        flush_i = 1'b1;
        next_cycle();
        flush_i = 1'b0;
        check_quiet();
        apply_correct(branch_pkg::BR_BGE, rand_data(), rand_data(), 32'h10, rand_pc());
        next_cycle();
        check_result();
        drive_idle();
        next_cycle();
        check_quiet();
    endtask

    // ----------------------------------------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------------------------------------

    initial begin : watchdog
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        abort_run("Watchdog expired before the tests finished");
    end

    initial begin : main
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        fe_ready_i = 1'b0;
        drive_idle();
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        test_reset();
        test_conditions();
        test_jumps();
        test_mispredict(1'b0);
        test_mispredict(1'b1);
        test_flush_in_mis();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
